/* common/irem_consts.svh */
//================================================
// Irem arcade glue constants
// ROM region bounds, download indexes, core
// variant codes and default hold and dim counts
//================================================

`ifndef IREM_CONSTS_SVH
`define IREM_CONSTS_SVH

// ================================================
// ROM image layout, byte addresses
// ================================================

// Sound CPU ROM occupies 0x20000 up to the graphics base
`define IREM_SND_BASE 25'h20000
// Sprite and graphics data, mirrored onto memory port 2
`define IREM_GFX_BASE 25'h30000

// ================================================
// Download indexes
// ================================================

`define IREM_IDX_ROM 8'd0
`define IREM_IDX_MOD 8'd1
`define IREM_IDX_DIP 8'd254

// Core variants with a portrait screen
`define IREM_MOD_PORTRAIT     8'h06
`define IREM_MOD_PORTRAIT_CCW 8'h0B

// Default timing in clk_sys cycles
`define IREM_RESET_HOLD 65535
`define IREM_DIM_CYCLES 240000000

`endif

/* common/irem_pkg.sv */
//================================================
// Irem arcade glue types
// Packed structs shared by the glue blocks
//================================================

`default_nettype none

package irem_pkg;

	// One beat of the indexed download stream
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_beat_t;

	// 16-bit memory write, ds[1] selects the upper (odd) byte
	typedef struct packed {
		logic [22:0] addr;
		logic [1:0]  ds;
		logic [15:0] data;
	} mem_wr_t;

	// Sound ROM write port
	typedef struct packed {
		logic        we;
		logic [15:0] addr;
		logic [7:0]  data;
	} snd_wr_t;

	// 12-bit colour, 4 bits per channel
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb12_t;

	// Screen orientation decoded from the core variant
	typedef struct packed {
		logic landscape;
		logic ccw;
	} core_cfg_t;

endpackage

`default_nettype wire

/* download/config_capture.sv */
//================================================
// Configuration capture
// Latches the core variant and DIP switch bytes
// and decodes the screen orientation
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "irem_consts.svh"

module config_capture (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  irem_pkg::dl_beat_t  dl,
	output logic [7:0]          core_mod,
	output logic [7:0]          sw0,
	output logic [7:0]          sw1,
	output irem_pkg::core_cfg_t cfg
);

	logic [7:0] sw_bank [8];
	logic       mod_hit;
	logic       dip_hit;

	assign mod_hit = dl.wr & (dl.index == `IREM_IDX_MOD);
	// DIP bank holds 8 bytes, anything beyond is ignored
	assign dip_hit = dl.wr & (dl.index == `IREM_IDX_DIP) & (dl.addr[24:3] == '0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			core_mod <= '0;
			for (int i = 0; i < 8; i++) begin
				sw_bank[i] <= '0;
			end
		end else begin
			if (mod_hit) begin
				core_mod <= dl.data;
			end
			if (dip_hit) begin
				sw_bank[dl.addr[2:0]] <= dl.data;
			end
		end
	end

	// The core only reads the first two switch banks
	assign sw0 = sw_bank[0];
	assign sw1 = sw_bank[1];

	// Orientation decode, landscape unless listed
	always_comb begin
		case (core_mod)
			`IREM_MOD_PORTRAIT:     cfg = '{landscape: 1'b0, ccw: 1'b0};
			`IREM_MOD_PORTRAIT_CCW: cfg = '{landscape: 1'b0, ccw: 1'b1};
			default:                cfg = '{landscape: 1'b1, ccw: 1'b0};
		endcase
	end

endmodule

`default_nettype wire

/* download/rom_download_router.sv */
//================================================
// ROM download router
// Turns index-0 download beats into toggle-request
// memory writes and sound ROM writes, and flags
// the end of a ROM download
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "irem_consts.svh"

module rom_download_router (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  irem_pkg::dl_beat_t dl,
	input  logic               downloading,
	output irem_pkg::mem_wr_t  port1_wr,
	output logic               port1_req,
	output irem_pkg::mem_wr_t  port2_wr,
	output logic               port2_req,
	output irem_pkg::snd_wr_t  snd_wr,
	output logic               rom_loaded
);
	import irem_pkg::*;

	logic        wr_q;
	logic        downloading_q;
	logic        rom_write;
	logic        snd_hit;
	logic        in_gfx;
	logic        in_snd;
	logic [24:0] gfx_off;
	mem_wr_t     port1_next;
	mem_wr_t     port2_next;
	logic        snd_we_q;
	logic [15:0] snd_addr_q;
	logic [7:0]  snd_data_q;

	// ================================================
	// Region decode
	// ================================================

	assign in_gfx  = dl.addr >= `IREM_GFX_BASE;
	assign in_snd  = (dl.addr >= `IREM_SND_BASE) & ~in_gfx;
	assign gfx_off = dl.addr - `IREM_GFX_BASE;

	// Only the rising edge of wr starts a memory write
	assign rom_write = dl.wr & ~wr_q & downloading & (dl.index == `IREM_IDX_ROM);
	// Sound ROM is written on every wr-high cycle
	assign snd_hit = dl.wr & downloading & (dl.index == `IREM_IDX_ROM) & in_snd;

	// Byte goes on both lanes, strobe picks the lane
	assign port1_next = '{
		addr: dl.addr[23:1],
		ds:   {dl.addr[0], ~dl.addr[0]},
		data: {2{dl.data}}
	};
	assign port2_next = '{
		addr: gfx_off[23:1],
		ds:   {gfx_off[0], ~gfx_off[0]},
		data: {2{dl.data}}
	};

	// ================================================
	// Control state
	// ================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_q          <= 1'b0;
			downloading_q <= 1'b0;
			port1_req     <= 1'b0;
			port2_req     <= 1'b0;
			snd_we_q      <= 1'b0;
			rom_loaded    <= 1'b0;
		end else begin
			wr_q          <= dl.wr;
			downloading_q <= downloading;
			snd_we_q      <= snd_hit;
			rom_loaded    <= downloading_q & ~downloading;
			if (rom_write) begin
				port1_req <= ~port1_req;
				if (in_gfx) begin
					port2_req <= ~port2_req;
				end
			end
		end
	end

	// Payloads, valid together with the request toggle
	always_ff @(posedge clk_sys) begin
		if (rom_write) begin
			port1_wr <= port1_next;
			if (in_gfx) begin
				port2_wr <= port2_next;
			end
		end
		if (snd_hit) begin
			snd_addr_q <= dl.addr[15:0];
			snd_data_q <= dl.data;
		end
	end

	assign snd_wr = '{we: snd_we_q, addr: snd_addr_q, data: snd_data_q};

endmodule

`default_nettype wire

/* hdl/arcade_glue_top.sv */
//================================================
// Irem arcade glue, top level
// Download routing, configuration capture, core
// reset sequencing and the pause system
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "irem_consts.svh"

module arcade_glue_top #(
	parameter int hold_cycles = `IREM_RESET_HOLD,
	parameter int dim_cycles  = `IREM_DIM_CYCLES
) (
	input  logic                clk_sys,
	input  logic                arst_n,
	// Download stream
	input  irem_pkg::dl_beat_t  dl,
	input  logic                downloading,
	output irem_pkg::mem_wr_t   port1_wr,
	output logic                port1_req,
	output irem_pkg::mem_wr_t   port2_wr,
	output logic                port2_req,
	output irem_pkg::snd_wr_t   snd_wr,
	// Configuration
	output logic [7:0]          core_mod,
	output logic [7:0]          sw0,
	output logic [7:0]          sw1,
	output irem_pkg::core_cfg_t cfg,
	// Reset
	input  logic                menu_reset,
	input  logic                user_reset,
	output logic                core_reset,
	// Pause and video
	input  logic                pause_btn,
	input  logic                osd_open,
	input  logic                osd_pause_off,
	input  irem_pkg::rgb12_t    rgb_in,
	output logic                pause,
	output irem_pkg::rgb12_t    rgb_out
);

	logic rom_loaded;

	rom_download_router i_router (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl          (dl),
		.downloading (downloading),
		.port1_wr    (port1_wr),
		.port1_req   (port1_req),
		.port2_wr    (port2_wr),
		.port2_req   (port2_req),
		.snd_wr      (snd_wr),
		.rom_loaded  (rom_loaded)
	);

	config_capture i_config (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.dl       (dl),
		.core_mod (core_mod),
		.sw0      (sw0),
		.sw1      (sw1),
		.cfg      (cfg)
	);

	reset_sequencer #(
		.hold_cycles (hold_cycles)
	) i_reset (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.rom_loaded (rom_loaded),
		.menu_reset (menu_reset),
		.user_reset (user_reset),
		.core_reset (core_reset)
	);

	pause_dimmer #(
		.dim_cycles (dim_cycles)
	) i_pause (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.pause_btn     (pause_btn),
		.osd_open      (osd_open),
		.osd_pause_off (osd_pause_off),
		.rgb_in        (rgb_in),
		.pause         (pause),
		.rgb_out       (rgb_out)
	);

endmodule

`default_nettype wire

/* hdl/pause_dimmer.sv */
//================================================
// Pause and dimming
// Pause toggle from the button or the open OSD,
// and half-intensity video after a long pause
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "irem_consts.svh"

module pause_dimmer #(
	parameter int dim_cycles = `IREM_DIM_CYCLES
) (
	input  logic             clk_sys,
	input  logic             arst_n,
	input  logic             pause_btn,
	input  logic             osd_open,
	input  logic             osd_pause_off,
	input  irem_pkg::rgb12_t rgb_in,
	output logic             pause,
	output irem_pkg::rgb12_t rgb_out
);
	import irem_pkg::*;

	localparam int tmr_w = (dim_cycles < 1) ? 1 : $clog2(dim_cycles + 1);
	localparam logic [tmr_w-1:0] dim_max = tmr_w'(dim_cycles);

	logic             btn_q;
	logic             pause_toggle;
	logic [tmr_w-1:0] pause_timer;
	logic             dim_video;
	rgb12_t           rgb_half;

	// Open menu pauses too, unless the user turned that off
	assign pause = pause_toggle | (osd_open & ~osd_pause_off);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			btn_q        <= 1'b0;
			pause_toggle <= 1'b0;
			pause_timer  <= '0;
		end else begin
			btn_q <= pause_btn;
			if (pause_btn & ~btn_q) begin
				pause_toggle <= ~pause_toggle;
			end
			// Timer saturates at the dim count
			if (!pause) begin
				pause_timer <= '0;
			end else if (pause_timer < dim_max) begin
				pause_timer <= pause_timer + 1'b1;
			end
		end
	end

	// ================================================
	// Video dimming
	// ================================================

	assign dim_video = pause_timer >= dim_max;

	assign rgb_half = '{
		r: rgb_in.r >> 1,
		g: rgb_in.g >> 1,
		b: rgb_in.b >> 1
	};

	assign rgb_out = dim_video ? rgb_half : rgb_in;

endmodule

`default_nettype wire

/* hdl/reset_sequencer.sv */
//================================================
// Core reset sequencer
// Keeps the game core in reset until a ROM is
// loaded and for a hold time after each request
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "irem_consts.svh"

module reset_sequencer #(
	parameter int hold_cycles = `IREM_RESET_HOLD
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic rom_loaded,
	input  logic menu_reset,
	input  logic user_reset,
	output logic core_reset
);

	localparam int cnt_w = (hold_cycles < 1) ? 1 : $clog2(hold_cycles + 1);
	localparam logic [cnt_w-1:0] hold_val = cnt_w'(hold_cycles);

	logic             loaded;
	logic [cnt_w-1:0] hold_cnt;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			loaded     <= 1'b0;
			hold_cnt   <= hold_val;
			core_reset <= 1'b1;
		end else begin
			// Sticky, a finished ROM download stays valid
			if (rom_loaded) begin
				loaded <= 1'b1;
			end
			if (menu_reset | user_reset | ~loaded) begin
				hold_cnt <= hold_val;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			core_reset <= hold_cnt != '0;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the arcade glue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
	--top-module tb_arcade_glue -o tb_arcade_glue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_arcade_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* sources.f */
+incdir+common
common/irem_pkg.sv
download/rom_download_router.sv
download/config_capture.sv
hdl/reset_sequencer.sv
hdl/pause_dimmer.sv
hdl/arcade_glue_top.sv
verification/tb_arcade_glue.sv

/* verification/tb_arcade_glue.sv */
//================================================
// Arcade glue testbench
// Table-driven download, configuration, core
// reset and pause checks against the top level
//================================================

`timescale 1ns/1ps
`default_nettype none

module tb_arcade_glue;
	import irem_pkg::*;

	localparam int          hold_cycles = 32;
	localparam int          dim_cycles  = 50;
	localparam logic [24:0] snd_base    = 25'h20000;
	localparam logic [24:0] gfx_base    = 25'h30000;

	// One table row, data is random unless fixed is set
	typedef struct packed {
		logic [7:0]  index;
		logic [24:0] addr;
		logic        dnl;
		logic        fixed;
		logic [7:0]  data;
	} row_t;

	logic       clk_sys;
	logic       arst_n;
	dl_beat_t   dl;
	logic       downloading;
	mem_wr_t    port1_wr;
	logic       port1_req;
	mem_wr_t    port2_wr;
	logic       port2_req;
	snd_wr_t    snd_wr;
	logic [7:0] core_mod;
	logic [7:0] sw0;
	logic [7:0] sw1;
	core_cfg_t  cfg;
	logic       menu_reset;
	logic       user_reset;
	logic       core_reset;
	logic       pause_btn;
	logic       osd_open;
	logic       osd_pause_off;
	rgb12_t     rgb_in;
	logic       pause;
	rgb12_t     rgb_out;

	row_t        rows [$];
	integer      seed;
	int          value_errs;
	int          other_errs;
	logic        exp_p1_req;
	logic        exp_p2_req;
	mem_wr_t     exp_p1;
	mem_wr_t     exp_p2;
	logic        p1_seen;
	logic        p2_seen;
	logic [15:0] exp_snd_addr;
	logic [7:0]  exp_snd_data;
	logic [7:0]  exp_mod;
	logic [7:0]  exp_sw0;
	logic [7:0]  exp_sw1;

	arcade_glue_top #(
		.hold_cycles (hold_cycles),
		.dim_cycles  (dim_cycles)
	) i_dut (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.dl            (dl),
		.downloading   (downloading),
		.port1_wr      (port1_wr),
		.port1_req     (port1_req),
		.port2_wr      (port2_wr),
		.port2_req     (port2_req),
		.snd_wr        (snd_wr),
		.core_mod      (core_mod),
		.sw0           (sw0),
		.sw1           (sw1),
		.cfg           (cfg),
		.menu_reset    (menu_reset),
		.user_reset    (user_reset),
		.core_reset    (core_reset),
		.pause_btn     (pause_btn),
		.osd_open      (osd_open),
		.osd_pause_off (osd_pause_off),
		.rgb_in        (rgb_in),
		.pause         (pause),
		.rgb_out       (rgb_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ================================================
	// Reference rules and reporting
	// ================================================

	function automatic mem_wr_t expected_mem(input logic [24:0] a, input logic [7:0] d);
		mem_wr_t w;
		w.addr = 23'(a >> 1);
		// Odd bytes land on the upper lane
		w.ds   = a[0] ? 2'b10 : 2'b01;
		w.data = {d, d};
		return w;
	endfunction

	function automatic core_cfg_t expected_cfg(input logic [7:0] m);
		core_cfg_t c;
		c.landscape = !(m == 8'h06 || m == 8'h0B);
		c.ccw       = (m == 8'h0B);
		return c;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		$display("Error at time %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
		value_errs++;
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at time %0t: %s", $time, msg);
		other_errs++;
	endtask

	task automatic add_row(input logic [7:0] index, input logic [24:0] addr,
			input logic dnl, input logic fixed, input logic [7:0] data);
		row_t r;
		r.index = index;
		r.addr  = addr;
		r.dnl   = dnl;
		r.fixed = fixed;
		r.data  = data;
		rows.push_back(r);
	endtask

	// Compares every download and configuration output with the model
	task automatic check_download(input logic snd_exp);
		if (port1_req !== exp_p1_req)
			report_mismatch("port1_req", exp_p1_req, port1_req);
		if (port2_req !== exp_p2_req)
			report_mismatch("port2_req", exp_p2_req, port2_req);
		if (p1_seen && port1_wr !== exp_p1)
			report_mismatch("port1_wr", exp_p1, port1_wr);
		if (p2_seen && port2_wr !== exp_p2)
			report_mismatch("port2_wr", exp_p2, port2_wr);
		if (snd_wr.we !== snd_exp)
			report_mismatch("snd_wr.we", snd_exp, snd_wr.we);
		if (snd_exp && snd_wr.addr !== exp_snd_addr)
			report_mismatch("snd_wr.addr", exp_snd_addr, snd_wr.addr);
		if (snd_exp && snd_wr.data !== exp_snd_data)
			report_mismatch("snd_wr.data", exp_snd_data, snd_wr.data);
		if (core_mod !== exp_mod)
			report_mismatch("core_mod", exp_mod, core_mod);
		if (sw0 !== exp_sw0)
			report_mismatch("sw0", exp_sw0, sw0);
		if (sw1 !== exp_sw1)
			report_mismatch("sw1", exp_sw1, sw1);
		if (cfg !== expected_cfg(exp_mod))
			report_mismatch("cfg", expected_cfg(exp_mod), cfg);
		if (core_reset !== 1'b1)
			report_failure("core_reset dropped while the download table ran");
	endtask

	// Counts cycles until core_reset falls
	task automatic wait_core_release(input string what);
		int n;
		n = 0;
		while (core_reset !== 1'b0 && n < hold_cycles + 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_reset !== 1'b0)
			report_failure({"core_reset never fell after ", what});
		else if (n < hold_cycles - 2)
			report_failure({"core_reset fell before the hold time after ", what});
	endtask

	task automatic check_reset_request(input logic use_menu);
		int n;
		if (use_menu) begin
			menu_reset = 1'b1;
		end else begin
			user_reset = 1'b1;
		end
		@(negedge clk_sys);
		menu_reset = 1'b0;
		user_reset = 1'b0;
		n = 0;
		while (core_reset !== 1'b1 && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_reset !== 1'b1)
			report_failure("core_reset did not rise after a reset request");
		wait_core_release("a reset request");
	endtask

	task automatic check_pause();
		int n;
		rgb_in    = 12'hA5F;
		pause_btn = 1'b1;
		@(negedge clk_sys);
		pause_btn = 1'b0;
		if (pause !== 1'b1)
			report_mismatch("pause", 1'b1, pause);
		if (rgb_out !== rgb_in)
			report_mismatch("rgb_out", rgb_in, rgb_out);
		n = 0;
		while (rgb_out === rgb_in && n < dim_cycles + 10) begin
			@(negedge clk_sys);
			n++;
		end
		if (rgb_out === rgb_in)
			report_failure("video was never dimmed during a long pause");
		else if (n < dim_cycles - 2)
			report_failure("video was dimmed before the pause time ran out");
		// A5F at half intensity per channel
		if (rgb_out !== 12'h527)
			report_mismatch("rgb_out", 12'h527, rgb_out);
		// Second press releases pause
		pause_btn = 1'b1;
		@(negedge clk_sys);
		pause_btn = 1'b0;
		if (pause !== 1'b0)
			report_mismatch("pause", 1'b0, pause);
		n = 0;
		while (rgb_out !== rgb_in && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (rgb_out !== rgb_in)
			report_failure("video stayed dimmed after pause was released");
		osd_open = 1'b1;
		@(negedge clk_sys);
		if (pause !== 1'b1)
			report_mismatch("pause", 1'b1, pause);
		osd_pause_off = 1'b1;
		@(negedge clk_sys);
		if (pause !== 1'b0)
			report_mismatch("pause", 1'b0, pause);
		osd_open      = 1'b0;
		osd_pause_off = 1'b0;
	endtask

	// ================================================
	// Main sequence
	// ================================================

	initial begin
		row_t       r;
		logic [7:0] data;
		logic       rom;
		logic       snd;
		seed          = 58;
		value_errs    = 0;
		other_errs    = 0;
		arst_n        = 1'b0;
		dl            = '0;
		downloading   = 1'b0;
		menu_reset    = 1'b0;
		user_reset    = 1'b0;
		pause_btn     = 1'b0;
		osd_open      = 1'b0;
		osd_pause_off = 1'b0;
		rgb_in        = '0;
		exp_p1_req    = 1'b0;
		exp_p2_req    = 1'b0;
		exp_p1        = '0;
		exp_p2        = '0;
		p1_seen       = 1'b0;
		p2_seen       = 1'b0;
		exp_snd_addr  = '0;
		exp_snd_data  = '0;
		exp_mod       = '0;
		exp_sw0       = '0;
		exp_sw1       = '0;

		// Rows with downloading low come first, so no early rom_loaded
		add_row(8'd0,   25'h00100, 1'b0, 1'b0, 8'h00);
		add_row(8'd0,   25'h30004, 1'b0, 1'b0, 8'h00);
		add_row(8'd1,   25'h00000, 1'b0, 1'b1, 8'h06);
		add_row(8'd1,   25'h00000, 1'b0, 1'b1, 8'h0B);
		add_row(8'd254, 25'h00000, 1'b0, 1'b1, 8'h5A);
		add_row(8'd254, 25'h00001, 1'b0, 1'b1, 8'hC3);
		add_row(8'd254, 25'h00009, 1'b0, 1'b1, 8'hFF);
		add_row(8'd1,   25'h00000, 1'b0, 1'b1, 8'h03);
		add_row(8'd0,   25'h00000, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h00001, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h1FFFF, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h20000, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h2ABCD, 1'b1, 1'b0, 8'h00);
		add_row(8'd2,   25'h20010, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h2FFFF, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h30000, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h30001, 1'b1, 1'b0, 8'h00);
		add_row(8'd0,   25'h3F123, 1'b1, 1'b0, 8'h00);

		repeat (5) @(negedge clk_sys);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", 1'b1, core_reset);
		if (pause !== 1'b0)
			report_mismatch("pause", 1'b0, pause);
		check_download(1'b0);
		arst_n = 1'b1;
		@(negedge clk_sys);

		for (int i = 0; i < rows.size(); i++) begin
			r    = rows[i];
			data = r.fixed ? r.data : 8'($random(seed));
			rom  = r.dnl && r.index == 8'd0;
			snd  = rom && r.addr >= snd_base && r.addr < gfx_base;
			dl          = '{wr: 1'b1, index: r.index, addr: r.addr, data: data};
			downloading = r.dnl;
			if (rom) begin
				exp_p1_req = ~exp_p1_req;
				exp_p1     = expected_mem(r.addr, data);
				p1_seen    = 1'b1;
				if (r.addr >= gfx_base) begin
					exp_p2_req = ~exp_p2_req;
					exp_p2     = expected_mem(r.addr - gfx_base, data);
					p2_seen    = 1'b1;
				end
			end
			if (snd) begin
				exp_snd_addr = r.addr[15:0];
				exp_snd_data = data;
			end
			if (r.index == 8'd1)
				exp_mod = data;
			if (r.index == 8'd254 && r.addr == 25'd0)
				exp_sw0 = data;
			if (r.index == 8'd254 && r.addr == 25'd1)
				exp_sw1 = data;
			@(negedge clk_sys);
			check_download(snd);
			dl.wr = 1'b0;
			@(negedge clk_sys);
			check_download(1'b0);
		end

		downloading = 1'b0;
		wait_core_release("the download");
		check_reset_request(1'b1);
		check_reset_request(1'b0);
		check_pause();

		$display("Checks done: %0d value errors, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
